// ==== design/sfr_params.svh ====
// SFR block parameters
`ifndef SFR_PARAMS_SVH
`define SFR_PARAMS_SVH

// Sprite attribute table window
`define SAT_BASE           16'h0200
`define SAT_LAST           16'h05FF
`define SAT_BYTES          1024

// Register blocks, 16 registers each
`define REG_BLOCK_REGS     16
`define VIDEO_BASE         16'h7F00
`define STATUS_BASE        16'h7F10

// Video block indices
`define IDX_VRAM_FLAGS     4'd0
`define IDX_SCROLL_X       4'd1
`define IDX_SCROLL_Y       4'd2
`define IDX_SCREEN_CTRL    4'd3
`define IDX_PALETTE_ADDR   4'd4
`define IDX_PALETTE_DATA   4'd5

// Status block indices
`define IDX_GAMEPAD1       4'd0
`define IDX_GAMEPAD2       4'd1
`define IDX_INPUT_STATUS   4'd2
`define IDX_FRAME_LO       4'd3
`define IDX_FRAME_HI       4'd4
`define IDX_RAND           4'd5
`define IDX_VSYNC_STATUS   4'd6

`define GAMEPAD_RESET      8'hFF    // All buttons released
`define RAND_DEFAULT_SEED  8'hCE
`define RAND_TAPS          8'hB8    // Bits 7, 5, 4, 3

`endif

// ==== design/sfr_pkg.sv ====
// SFR shared types
package sfr_pkg;

    typedef logic [7:0]  sfr_data_t;   // One bus byte
    typedef logic [15:0] sfr_addr_t;   // CPU address inside the SFR window
    typedef logic [9:0]  sat_addr_t;   // SAT byte index
    typedef logic [3:0]  reg_idx_t;    // Register index inside a block

    // Screen control fields
    typedef struct packed {
        logic [5:0] reserved;
        logic       graphics_mode;
        logic       display_enable;
    } screen_ctrl_t;

    // Screen control seen as a bus byte or as fields
    typedef union packed {
        sfr_data_t    raw;
        screen_ctrl_t fields;
    } screen_ctrl_u;

endpackage

// ==== design/sfr_bus_if.sv ====
// SFR register bus
`timescale 1ns/1ps

interface sfr_bus_if #(
    parameter int OFFSET_W = 4
);
    logic                  wr;      // Write strobe for this block
    logic                  rd;      // Read strobe, drives read side effects
    logic [OFFSET_W-1:0]   offset;  // Relative to block base
    sfr_pkg::sfr_data_t    wdata;
    sfr_pkg::sfr_data_t    rdata;   // Combinational from block registers

    modport host (
        output wr, rd, offset, wdata,
        input  rdata
    );

    modport block (
        input  wr, rd, offset, wdata,
        output rdata
    );

endinterface

// ==== design/sfr_decode.sv ====
// SFR address decoder
`timescale 1ns/1ps
`include "sfr_params.svh"

module sfr_decode (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                cs,
    input  logic                wr_en,
    input  sfr_pkg::sfr_addr_t  addr,
    input  sfr_pkg::sfr_data_t  wdata,
    output sfr_pkg::sfr_data_t  rdata,
    sfr_bus_if.host             sat_bus,
    sfr_bus_if.host             video_bus,
    sfr_bus_if.host             status_bus
);
    import sfr_pkg::*;

    localparam sfr_addr_t VIDEO_LAST  = sfr_addr_t'(`VIDEO_BASE + `REG_BLOCK_REGS - 1);
    localparam sfr_addr_t STATUS_LAST = sfr_addr_t'(`STATUS_BASE + `REG_BLOCK_REGS - 1);

    logic      sat_sel;
    logic      video_sel;
    logic      status_sel;
    sfr_addr_t sat_rel;

    assign sat_sel    = cs && (addr >= `SAT_BASE) && (addr <= `SAT_LAST);
    assign video_sel  = cs && (addr >= `VIDEO_BASE) && (addr <= VIDEO_LAST);
    assign status_sel = cs && (addr >= `STATUS_BASE) && (addr <= STATUS_LAST);

    assign sat_rel = addr - `SAT_BASE;

    // Strobes go only to the selected block
    assign sat_bus.wr    = sat_sel && wr_en;
    assign sat_bus.rd    = sat_sel && !wr_en;
    assign sat_bus.offset = sat_addr_t'(sat_rel);
    assign sat_bus.wdata = wdata;

    assign video_bus.wr     = video_sel && wr_en;
    assign video_bus.rd     = video_sel && !wr_en;
    assign video_bus.offset = reg_idx_t'(addr);   // Low nibble
    assign video_bus.wdata  = wdata;

    assign status_bus.wr     = status_sel && wr_en;
    assign status_bus.rd     = status_sel && !wr_en;
    assign status_bus.offset = reg_idx_t'(addr);
    assign status_bus.wdata  = wdata;

    // Read data mux, unmapped reads return 0
    always_comb begin
        if (sat_sel) begin
            rdata = sat_bus.rdata;
        end else if (video_sel) begin
            rdata = video_bus.rdata;
        end else if (status_sel) begin
            rdata = status_bus.rdata;
        end else begin
            rdata = '0;
        end
    end

    // Only one block sees a strobe per cycle
    a_one_strobe: assert property (@(posedge clk) disable iff (!rst_n)
        $onehot0({sat_bus.wr, sat_bus.rd, video_bus.wr, video_bus.rd,
                  status_bus.wr, status_bus.rd}));

endmodule

// ==== design/sat_ram.sv ====
// Sprite attribute table
`timescale 1ns/1ps
`include "sfr_params.svh"

module sat_ram (
    input  logic                clk,
    input  logic                rst_n,
    input  sfr_pkg::sat_addr_t  sprite_sat_addr,
    output sfr_pkg::sfr_data_t  sprite_sat_data,
    sfr_bus_if.block            bus
);
    import sfr_pkg::*;

    sfr_data_t mem [0:`SAT_BYTES-1];

    // CPU write port, contents are not cleared
    always_ff @(posedge clk) begin
        if (bus.wr) begin
            mem[bus.offset] <= bus.wdata;
        end
    end

    assign bus.rdata = mem[bus.offset];   // CPU read, same cycle

    // Sprite engine read, one cycle latency
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sprite_sat_data <= '0;
        end else begin
            sprite_sat_data <= mem[sprite_sat_addr];
        end
    end

    a_wr_offset_known: assert property (@(posedge clk) disable iff (!rst_n)
        bus.wr |-> !$isunknown(bus.offset));

endmodule

// ==== design/video_regs.sv ====
// Video control registers
`timescale 1ns/1ps
`include "sfr_params.svh"

module video_regs (
    input  logic                clk,
    input  logic                rst_n,
    output logic                display_enable,
    output logic                graphics_mode,
    output logic                palette_wr,
    output sfr_pkg::sfr_data_t  scroll_x,
    output sfr_pkg::sfr_data_t  scroll_y,
    output sfr_pkg::sfr_data_t  vram_flags,
    output sfr_pkg::sfr_data_t  palette_addr,
    output sfr_pkg::sfr_data_t  palette_data,
    sfr_bus_if.block            bus
);
    import sfr_pkg::*;

    screen_ctrl_u screen_ctrl;
    sfr_data_t    palette_ptr;   // Auto-incrementing palette pointer
    logic         pal_data_wr;

    assign pal_data_wr = bus.wr && (bus.offset == `IDX_PALETTE_DATA);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            vram_flags      <= '0;
            scroll_x        <= '0;
            scroll_y        <= '0;
            screen_ctrl.raw <= '0;
            palette_ptr     <= '0;
            palette_addr    <= '0;
            palette_data    <= '0;
            palette_wr      <= 1'b0;
        end else begin
            palette_wr <= pal_data_wr;   // One-cycle pulse
            if (bus.wr) begin
                case (bus.offset)
                    `IDX_VRAM_FLAGS:   vram_flags      <= bus.wdata;
                    `IDX_SCROLL_X:     scroll_x        <= bus.wdata;
                    `IDX_SCROLL_Y:     scroll_y        <= bus.wdata;
                    `IDX_SCREEN_CTRL:  screen_ctrl.raw <= bus.wdata;
                    `IDX_PALETTE_ADDR: palette_ptr     <= bus.wdata;
                    `IDX_PALETTE_DATA: begin
                        palette_data <= bus.wdata;
                        palette_addr <= palette_ptr;        // Address before the step
                        palette_ptr  <= palette_ptr + 8'd1; // Wraps at 8 bits
                    end
                    default: ;
                endcase
            end
        end
    end

    assign display_enable = screen_ctrl.fields.display_enable;
    assign graphics_mode  = screen_ctrl.fields.graphics_mode;

    always_comb begin
        case (bus.offset)
            `IDX_VRAM_FLAGS:   bus.rdata = vram_flags;
            `IDX_SCROLL_X:     bus.rdata = scroll_x;
            `IDX_SCROLL_Y:     bus.rdata = scroll_y;
            `IDX_SCREEN_CTRL:  bus.rdata = screen_ctrl.raw;
            `IDX_PALETTE_ADDR: bus.rdata = palette_ptr;
            `IDX_PALETTE_DATA: bus.rdata = palette_data;
            default:           bus.rdata = '0;
        endcase
    end

    // During the pulse the pointer sits one past the shown address
    a_pal_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        palette_wr |-> (palette_ptr == palette_addr + 8'd1));

endmodule

// ==== design/rand_lfsr.sv ====
// Random number LFSR
`timescale 1ns/1ps
`include "sfr_params.svh"

module rand_lfsr (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                seed_wr,
    input  sfr_pkg::sfr_data_t  seed,
    output sfr_pkg::sfr_data_t  value
);
    import sfr_pkg::*;

    sfr_data_t next_value;

    // Shift left, feedback into bit 0
    assign next_value = {value[6:0], ^(value & `RAND_TAPS)};

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            value <= `RAND_DEFAULT_SEED;
        end else if (seed_wr) begin
            value <= (seed == '0) ? `RAND_DEFAULT_SEED : seed;   // Zero would lock up
        end else begin
            value <= next_value;
        end
    end

endmodule

// ==== design/system_status.sv ====
// System status registers
`timescale 1ns/1ps
`include "sfr_params.svh"

module system_status (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                in_vblank,
    input  logic                new_frame,
    input  logic                gamepad1_connected,
    input  logic                gamepad2_connected,
    input  sfr_pkg::sfr_data_t  gamepad1,
    input  sfr_pkg::sfr_data_t  gamepad2,
    sfr_bus_if.block            bus
);
    import sfr_pkg::*;

    sfr_data_t   gamepad1_q;
    sfr_data_t   gamepad2_q;
    logic [1:0]  connected_q;
    logic [15:0] frame_cnt;
    sfr_data_t   frame_hi_latch;   // Captured on FRAME_LO read
    logic        vblank_q;
    logic        new_frame_flag;
    sfr_data_t   rand_value;
    logic        rd_frame_lo;
    logic        rd_vsync;

    assign rd_frame_lo = bus.rd && (bus.offset == `IDX_FRAME_LO);
    assign rd_vsync    = bus.rd && (bus.offset == `IDX_VSYNC_STATUS);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            gamepad1_q     <= `GAMEPAD_RESET;
            gamepad2_q     <= `GAMEPAD_RESET;
            connected_q    <= '0;
            frame_cnt      <= '0;
            frame_hi_latch <= '0;
            vblank_q       <= 1'b0;
            new_frame_flag <= 1'b0;
        end else begin
            gamepad1_q  <= gamepad1;
            gamepad2_q  <= gamepad2;
            connected_q <= {gamepad2_connected, gamepad1_connected};
            vblank_q    <= in_vblank;
            if (rd_frame_lo) begin
                frame_hi_latch <= frame_cnt[15:8];
            end
            if (rd_vsync) begin
                new_frame_flag <= 1'b0;   // Clear on read
            end
            if (new_frame) begin
                new_frame_flag <= 1'b1;   // Set beats a same-cycle clear
                frame_cnt      <= frame_cnt + 16'd1;
            end
        end
    end

    rand_lfsr u_rand_lfsr (
        .clk     (clk),
        .rst_n   (rst_n),
        .seed_wr (bus.wr && (bus.offset == `IDX_RAND)),
        .seed    (bus.wdata),
        .value   (rand_value)
    );

    always_comb begin
        case (bus.offset)
            `IDX_GAMEPAD1:     bus.rdata = gamepad1_q;
            `IDX_GAMEPAD2:     bus.rdata = gamepad2_q;
            `IDX_INPUT_STATUS: bus.rdata = {6'b0, connected_q};
            `IDX_FRAME_LO:     bus.rdata = frame_cnt[7:0];
            `IDX_FRAME_HI:     bus.rdata = frame_hi_latch;
            `IDX_RAND:         bus.rdata = rand_value;
            `IDX_VSYNC_STATUS: bus.rdata = {6'b0, new_frame_flag, vblank_q};
            default:           bus.rdata = '0;
        endcase
    end

    a_new_frame_flag: assert property (@(posedge clk) disable iff (!rst_n)
        new_frame |=> new_frame_flag);

endmodule

// ==== design/sfr_block.sv ====
// SFR block top level
`timescale 1ns/1ps

module sfr_block (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                cs,
    input  logic                wr_en,
    input  sfr_pkg::sfr_addr_t  addr,
    input  sfr_pkg::sfr_data_t  wdata,
    output sfr_pkg::sfr_data_t  rdata,
    // Video outputs
    output sfr_pkg::sfr_data_t  scroll_x,
    output sfr_pkg::sfr_data_t  scroll_y,
    output sfr_pkg::sfr_data_t  vram_flags,
    output sfr_pkg::sfr_data_t  palette_addr,
    output sfr_pkg::sfr_data_t  palette_data,
    output logic                display_enable,
    output logic                graphics_mode,
    output logic                palette_wr,
    // Sprite engine port
    input  sfr_pkg::sat_addr_t  sprite_sat_addr,
    output sfr_pkg::sfr_data_t  sprite_sat_data,
    // Frame timing and gamepads
    input  logic                in_vblank,
    input  logic                new_frame,
    input  logic                gamepad1_connected,
    input  logic                gamepad2_connected,
    input  sfr_pkg::sfr_data_t  gamepad1,
    input  sfr_pkg::sfr_data_t  gamepad2
);
    import sfr_pkg::*;

    sfr_bus_if #(.OFFSET_W($bits(sat_addr_t))) sat_bus ();
    sfr_bus_if #(.OFFSET_W($bits(reg_idx_t)))  video_bus ();
    sfr_bus_if #(.OFFSET_W($bits(reg_idx_t)))  status_bus ();

    sfr_decode u_sfr_decode (
        .clk        (clk),
        .rst_n      (rst_n),
        .cs         (cs),
        .wr_en      (wr_en),
        .addr       (addr),
        .wdata      (wdata),
        .rdata      (rdata),
        .sat_bus    (sat_bus.host),
        .video_bus  (video_bus.host),
        .status_bus (status_bus.host)
    );

    sat_ram u_sat_ram (
        .clk             (clk),
        .rst_n           (rst_n),
        .sprite_sat_addr (sprite_sat_addr),
        .sprite_sat_data (sprite_sat_data),
        .bus             (sat_bus.block)
    );

    video_regs u_video_regs (
        .clk            (clk),
        .rst_n          (rst_n),
        .display_enable (display_enable),
        .graphics_mode  (graphics_mode),
        .palette_wr     (palette_wr),
        .scroll_x       (scroll_x),
        .scroll_y       (scroll_y),
        .vram_flags     (vram_flags),
        .palette_addr   (palette_addr),
        .palette_data   (palette_data),
        .bus            (video_bus.block)
    );

    system_status u_system_status (
        .clk                (clk),
        .rst_n              (rst_n),
        .in_vblank          (in_vblank),
        .new_frame          (new_frame),
        .gamepad1_connected (gamepad1_connected),
        .gamepad2_connected (gamepad2_connected),
        .gamepad1           (gamepad1),
        .gamepad2           (gamepad2),
        .bus                (status_bus.block)
    );

endmodule

// ==== verif/sfr_block_tb.sv ====
// SFR block testbench
`timescale 1ns/1ps
`include "sfr_params.svh"

module sfr_block_tb;
    import sfr_pkg::*;

    logic      clk;
    logic      rst_n;
    logic      cs;
    logic      wr_en;
    sfr_addr_t addr;
    sfr_data_t wdata;
    sfr_data_t rdata;
    sfr_data_t scroll_x, scroll_y, vram_flags;
    sfr_data_t palette_addr, palette_data;
    logic      display_enable, graphics_mode, palette_wr;
    sat_addr_t sprite_sat_addr;
    sfr_data_t sprite_sat_data;
    logic      in_vblank, new_frame;
    logic      gamepad1_connected, gamepad2_connected;
    sfr_data_t gamepad1, gamepad2;

    integer    seed;
    sfr_data_t sat_model [0:`SAT_BYTES-1];   // Expected SAT contents
    sat_addr_t sat_used [$];                 // Offsets written so far

    sfr_block u_sfr_block (.*);

    always #2 clk = ~clk;   // 4 ns period

    function automatic sfr_addr_t video_addr(reg_idx_t idx);
        return `VIDEO_BASE + sfr_addr_t'(idx);
    endfunction

    function automatic sfr_addr_t status_addr(reg_idx_t idx);
        return `STATUS_BASE + sfr_addr_t'(idx);
    endfunction

    // Reference step with taps 7, 5, 4 and 3, shifting left
    function automatic sfr_data_t lfsr_next(sfr_data_t v);
        return {v[6:0], v[7] ^ v[5] ^ v[4] ^ v[3]};
    endfunction

    task automatic end_with_failure();
        $display(">>> FAIL");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    task automatic check_byte(string name, sfr_data_t got, sfr_data_t exp);
        if (got !== exp) begin
            $display("FAIL time %0t %s got 0x%02h expected 0x%02h", $time, name, got, exp);
            end_with_failure();
        end
    endtask

    task automatic check_flag(string name, logic got, logic exp);
        if (got !== exp) begin
            $display("FAIL time %0t %s got %b expected %b", $time, name, got, exp);
            end_with_failure();
        end
    endtask

    // Entered 1 ns after a rising edge, returns at the same point of the next cycle
    task automatic cpu_write(sfr_addr_t target, sfr_data_t value);
        cs    = 1'b1;
        wr_en = 1'b1;
        addr  = target;
        wdata = value;
        @(posedge clk);
        #1;
        cs    = 1'b0;
        wr_en = 1'b0;
    endtask

    task automatic cpu_read(input sfr_addr_t target, output sfr_data_t value);
        cs    = 1'b1;
        wr_en = 1'b0;
        addr  = target;
        #2;              // Read data settled, edge still 1 ns away
        value = rdata;
        @(posedge clk);
        #1;
        cs = 1'b0;
    endtask

    task automatic expect_read(sfr_addr_t target, sfr_data_t exp, string name);
        sfr_data_t value;
        cpu_read(target, value);
        check_byte(name, value, exp);
    endtask

    task automatic wait_palette_pulse();
        int cycles;
        cycles = 0;
        while (palette_wr !== 1'b1 && cycles < 8) begin
            @(posedge clk);
            #1;
            cycles++;
        end
        if (palette_wr !== 1'b1) begin
            $display("Timeout: the palette write pulse never came");
            end_with_failure();
        end
    endtask

    task automatic pulse_new_frame();
        new_frame = 1'b1;
        @(posedge clk);
        #1;
        new_frame = 1'b0;
        @(posedge clk);
        #1;
    endtask

    task automatic test_reset_state();
        for (int i = 0; i <= 5; i++) begin
            expect_read(video_addr(reg_idx_t'(i)), 8'h00, $sformatf("video reg %0d", i));
        end
        check_flag("display_enable", display_enable, 1'b0);
        check_flag("graphics_mode", graphics_mode, 1'b0);
        check_flag("palette_wr", palette_wr, 1'b0);
        expect_read(16'h0000, 8'h00, "unmapped read");
    endtask

    task automatic test_video_regs();
        screen_ctrl_u ctrl;
        sfr_data_t    sx;
        sfr_data_t    sy;
        sfr_data_t    flags;
        sx    = sfr_data_t'($random(seed));
        sy    = sfr_data_t'($random(seed));
        flags = sfr_data_t'($random(seed));
        cpu_write(video_addr(`IDX_SCROLL_X), sx);
        check_byte("scroll_x", scroll_x, sx);
        cpu_write(video_addr(`IDX_SCROLL_Y), sy);
        check_byte("scroll_y", scroll_y, sy);
        cpu_write(video_addr(`IDX_VRAM_FLAGS), flags);
        check_byte("vram_flags", vram_flags, flags);

        ctrl.raw = 8'h00;
        ctrl.fields.display_enable = 1'b1;
        cpu_write(video_addr(`IDX_SCREEN_CTRL), ctrl.raw);
        check_flag("display_enable", display_enable, 1'b1);
        check_flag("graphics_mode", graphics_mode, 1'b0);
        expect_read(video_addr(`IDX_SCREEN_CTRL), ctrl.raw, "screen_ctrl");

        ctrl.fields.display_enable = 1'b0;
        ctrl.fields.graphics_mode  = 1'b1;
        cpu_write(video_addr(`IDX_SCREEN_CTRL), ctrl.raw);
        check_flag("display_enable", display_enable, 1'b0);
        check_flag("graphics_mode", graphics_mode, 1'b1);

        expect_read(video_addr(`IDX_SCROLL_X), sx, "scroll_x read");
        expect_read(video_addr(`IDX_SCROLL_Y), sy, "scroll_y read");
        expect_read(video_addr(`IDX_VRAM_FLAGS), flags, "vram_flags read");
    endtask

    task automatic test_palette_stream();
        sfr_data_t start;
        sfr_data_t pdata;
        start = 8'hFE;   // Crosses the pointer wrap
        cpu_write(video_addr(`IDX_PALETTE_ADDR), start);
        for (int i = 0; i < 3; i++) begin
            pdata = sfr_data_t'($random(seed));
            cpu_write(video_addr(`IDX_PALETTE_DATA), pdata);
            wait_palette_pulse();
            check_byte("palette_addr", palette_addr, start + sfr_data_t'(i));
            check_byte("palette_data", palette_data, pdata);
            @(posedge clk);
            #1;
            check_flag("palette_wr after pulse", palette_wr, 1'b0);
        end
        expect_read(video_addr(`IDX_PALETTE_ADDR), start + 8'd3, "palette pointer");
    endtask

    task automatic test_sat();
        integer    rnd;
        sat_addr_t off;
        sfr_data_t val;
        for (int i = 0; i < 32; i++) begin
            rnd = $random(seed);
            off = rnd[9:0];
            val = rnd[23:16];
            sat_model[off] = val;
            sat_used.push_back(off);
            cpu_write(`SAT_BASE + sfr_addr_t'(off), val);
        end
        foreach (sat_used[i]) begin
            off = sat_used[i];
            expect_read(`SAT_BASE + sfr_addr_t'(off), sat_model[off], "SAT CPU read");
            sprite_sat_addr = off;
            @(posedge clk);
            #1;
            check_byte("sprite_sat_data", sprite_sat_data, sat_model[off]);
        end
    endtask

    task automatic test_frame_vsync();
        int        frames;
        sfr_data_t value;
        frames = 300;
        repeat (frames) pulse_new_frame();
        // No FRAME_LO read yet, so the latch still holds its reset value
        expect_read(status_addr(`IDX_FRAME_HI), 8'h00, "frame_hi before latch");
        expect_read(status_addr(`IDX_FRAME_LO), sfr_data_t'(frames), "frame_lo");
        pulse_new_frame();   // Latch must hold the earlier high byte
        expect_read(status_addr(`IDX_FRAME_HI), sfr_data_t'(frames >> 8), "frame_hi latch");

        cpu_read(status_addr(`IDX_VSYNC_STATUS), value);
        check_flag("vsync new frame flag", value[1], 1'b1);
        cpu_read(status_addr(`IDX_VSYNC_STATUS), value);
        check_flag("vsync flag after clear", value[1], 1'b0);

        in_vblank = 1'b1;
        @(posedge clk);
        #1;
        cpu_read(status_addr(`IDX_VSYNC_STATUS), value);
        check_flag("vsync in_vblank high", value[0], 1'b1);
        in_vblank = 1'b0;
        @(posedge clk);
        #1;
        cpu_read(status_addr(`IDX_VSYNC_STATUS), value);
        check_flag("vsync in_vblank low", value[0], 1'b0);
    endtask

    task automatic test_gamepads_rand();
        sfr_data_t pad1;
        sfr_data_t pad2;
        sfr_data_t seed_val;
        sfr_data_t expected;
        pad1 = sfr_data_t'($random(seed));
        pad2 = sfr_data_t'($random(seed));
        gamepad1           = pad1;
        gamepad2           = pad2;
        gamepad1_connected = 1'b1;
        gamepad2_connected = 1'b0;
        @(posedge clk);
        #1;
        expect_read(status_addr(`IDX_GAMEPAD1), pad1, "gamepad1");
        expect_read(status_addr(`IDX_GAMEPAD2), pad2, "gamepad2");
        expect_read(status_addr(`IDX_INPUT_STATUS), 8'h01, "input status");

        seed_val = sfr_data_t'($random(seed)) | 8'h01;   // Nonzero seed
        cpu_write(status_addr(`IDX_RAND), seed_val);
        expected = seed_val;
        for (int i = 0; i < 6; i++) begin
            expect_read(status_addr(`IDX_RAND), expected, $sformatf("rand step %0d", i));
            expected = lfsr_next(expected);
        end
        cpu_write(status_addr(`IDX_RAND), 8'h00);
        expect_read(status_addr(`IDX_RAND), `RAND_DEFAULT_SEED, "rand zero seed");
    endtask

    initial begin
        seed               = 32'he362eaf4;
        clk                = 1'b0;
        rst_n              = 1'b0;
        cs                 = 1'b0;
        wr_en              = 1'b0;
        addr               = '0;
        wdata              = '0;
        sprite_sat_addr    = '0;
        in_vblank          = 1'b0;
        new_frame          = 1'b0;
        gamepad1_connected = 1'b0;
        gamepad2_connected = 1'b0;
        gamepad1           = '0;
        gamepad2           = '0;
        repeat (3) @(posedge clk);
        #1;
        rst_n = 1'b1;

        test_reset_state();
        test_video_regs();
        test_palette_stream();
        test_sat();
        test_frame_vsync();
        test_gamepads_rand();

        $display(">>> PASS");
        $finish;
    end

endmodule

// ==== sim.f ====
+incdir+design
design/sfr_pkg.sv
design/sfr_bus_if.sv
design/sfr_decode.sv
design/sat_ram.sv
design/video_regs.sv
design/rand_lfsr.sv
design/system_status.sv
design/sfr_block.sv
verif/sfr_block_tb.sv

// ==== Makefile ====
# Verilator simulation of the SFR block

TOP = sfr_block_tb

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build and run the testbench with Verilator"
	@echo "  clean  remove the build output"

test:
	verilator --binary --timing --assert --top-module $(TOP) -f sim.f
	@out=$$(./obj_dir/V$(TOP) 2>&1); \
	echo "$$out"; \
	echo "$$out" | grep -qF ">>> PASS"

clean:
	rm -rf obj_dir
